/* verilog/core_defs.svh */
// RV64 subset only; memory access is ld/sd (funct3 011) and ebreak is the only SYSTEM word
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

`define XLEN        64
`define REG_NUM     32
`define RESET_PC    64'h0000_0000_8000_0000

`define OPC_OP_IMM  7'b0010011
`define OPC_OP      7'b0110011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111
`define OPC_SYSTEM  7'b1110011

`define F3_ADD      3'b000
`define F3_SLT      3'b010
`define F3_XOR      3'b100
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F3_DWORD    3'b011      // ld and sd
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F7_SUB      7'b0100000

`endif

/* verilog/core_pkg.sv */
// stage-boundary types for the 5-stage core; field widths follow core_defs.svh
`default_nettype none
`include "core_defs.svh"

package core_pkg;

    typedef logic [`XLEN-1:0]            xlen_t;
    typedef logic [31:0]                 inst_t;
    typedef logic [$clog2(`REG_NUM)-1:0] reg_addr_t;

    typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR, SLT} alu_op_e;
    typedef enum logic [1:0] {IDLE, SETUP, ACCESS} apb_state_e;

    typedef struct packed {
        logic  valid;
        xlen_t pc;
        inst_t inst;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        alu_op_e   alu_op;
        xlen_t     src1;
        xlen_t     src2;
        xlen_t     store_data;
        reg_addr_t rd;
        logic      reg_we;
        logic      is_load;
        logic      is_store;
        logic      is_ebreak;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        xlen_t     alu_res;     // also the ld/sd address
        xlen_t     store_data;
        reg_addr_t rd;
        logic      reg_we;
        logic      is_load;
        logic      is_store;
        logic      is_ebreak;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        xlen_t     wdata;
        reg_addr_t rd;
        logic      reg_we;
        logic      is_ebreak;
    } mem_wb_t;

    // result a stage can hand back to decode
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        xlen_t     value;
        logic      is_load;
    } fwd_t;

endpackage

`default_nettype wire

/* verilog/if_stage.sv */
// fetch expects imem_data_i in the same cycle as imem_addr_o; a stop request is sticky until reset
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module if_stage import core_pkg::*; (
    input  logic   clk,
    input  logic   rst_i,
    input  logic   stall_i,
    input  logic   id_hold_i,
    input  logic   redirect_valid_i,
    input  logic   fetch_stop_i,
    input  xlen_t  redirect_pc_i,
    input  inst_t  imem_data_i,
    output xlen_t  imem_addr_o,
    output if_id_t if_id_o
);

    xlen_t pc_q;
    logic  stopped_q;      // ebreak seen in decode
    logic  advance;
    logic  fetch_ok;

    assign advance     = !stall_i && !id_hold_i;
    assign fetch_ok    = !stopped_q && !fetch_stop_i;
    assign imem_addr_o = pc_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q          <= `RESET_PC;
            stopped_q     <= 1'b0;
            if_id_o.valid <= 1'b0;
        end else begin
            if (fetch_stop_i)
                stopped_q <= 1'b1;
            if (advance) begin
                if (redirect_valid_i)
                    pc_q <= redirect_pc_i;
                else if (fetch_ok)
                    pc_q <= pc_q + xlen_t'(4);
                if_id_o.valid <= fetch_ok && !redirect_valid_i;  // squash the slot after a taken jump
                if_id_o.pc    <= pc_q;
                if_id_o.inst  <= imem_data_i;
            end
        end
    end

    // decode never redirects and halts on the same instruction
    assert property (@(posedge clk) disable iff (rst_i)
        !(redirect_valid_i && fetch_stop_i));

endmodule

`default_nettype wire

/* verilog/id_stage.sv */
// branches and jal resolve here, so their operands come through the same forwarding muxes
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module id_stage import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  logic      stall_i,
    input  if_id_t    if_id_i,
    input  fwd_t      ex_fwd_i,
    input  fwd_t      mem_fwd_i,
    input  fwd_t      wb_fwd_i,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    input  xlen_t     rs1_data_i,
    input  xlen_t     rs2_data_i,
    output logic      id_hold_o,
    output logic      redirect_valid_o,
    output logic      fetch_stop_o,
    output xlen_t     redirect_pc_o,
    output id_ex_t    id_ex_o
);

    inst_t      inst;
    logic [6:0] opcode;
    logic [2:0] funct3;
    xlen_t      imm_i, imm_s, imm_b, imm_j;
    xlen_t      rs1_val, rs2_val;
    logic       use_rs1, use_rs2, load_use, taken;
    id_ex_t     id_ex_d;

    // youngest producer wins, x0 is never forwarded
    function automatic xlen_t fwd_pick(input reg_addr_t rs, input xlen_t rf_val);
        xlen_t val;
        val = rf_val;
        if (rs != '0) begin
            if (ex_fwd_i.valid && ex_fwd_i.rd == rs)
                val = ex_fwd_i.value;
            else if (mem_fwd_i.valid && mem_fwd_i.rd == rs)
                val = mem_fwd_i.value;
            else if (wb_fwd_i.valid && wb_fwd_i.rd == rs)
                val = wb_fwd_i.value;
        end
        return val;
    endfunction

    assign inst       = if_id_i.inst;
    assign opcode     = inst[6:0];
    assign funct3     = inst[14:12];
    assign rs1_addr_o = inst[19:15];
    assign rs2_addr_o = inst[24:20];

    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    assign rs1_val = fwd_pick(rs1_addr_o, rs1_data_i);
    assign rs2_val = fwd_pick(rs2_addr_o, rs2_data_i);

    assign use_rs1 = opcode inside {`OPC_OP_IMM, `OPC_OP, `OPC_LOAD, `OPC_STORE, `OPC_BRANCH};
    assign use_rs2 = opcode inside {`OPC_OP, `OPC_STORE, `OPC_BRANCH};

    // ld result is not ready until it leaves memory
    assign load_use = if_id_i.valid && ex_fwd_i.valid && ex_fwd_i.is_load && ex_fwd_i.rd != '0
                      && ((use_rs1 && ex_fwd_i.rd == rs1_addr_o)
                      || (use_rs2 && ex_fwd_i.rd == rs2_addr_o));

    always_comb begin
        taken = 1'b0;
        if (opcode == `OPC_JAL)
            taken = 1'b1;
        else if (opcode == `OPC_BRANCH && funct3 == `F3_BEQ)
            taken = (rs1_val == rs2_val);
        else if (opcode == `OPC_BRANCH && funct3 == `F3_BNE)
            taken = (rs1_val != rs2_val);
    end

    assign id_hold_o        = load_use;
    assign redirect_valid_o = if_id_i.valid && taken && !load_use;
    assign redirect_pc_o    = if_id_i.pc + ((opcode == `OPC_JAL) ? imm_j : imm_b);
    assign fetch_stop_o     = if_id_i.valid && opcode == `OPC_SYSTEM && inst[20];

    always_comb begin
        id_ex_d            = '0;
        id_ex_d.valid      = if_id_i.valid && !load_use;   // bubble on load-use
        id_ex_d.pc         = if_id_i.pc;
        id_ex_d.alu_op     = ADD;
        id_ex_d.src1       = rs1_val;
        id_ex_d.src2       = (opcode == `OPC_OP) ? rs2_val : imm_i;
        id_ex_d.store_data = rs2_val;
        id_ex_d.rd         = inst[11:7];
        case (opcode)
            `OPC_OP_IMM, `OPC_OP: begin
                id_ex_d.reg_we = 1'b1;
                case (funct3)
                    `F3_SLT: id_ex_d.alu_op = SLT;
                    `F3_XOR: id_ex_d.alu_op = XOR;
                    `F3_OR:  id_ex_d.alu_op = OR;
                    `F3_AND: id_ex_d.alu_op = AND;
                    default: begin
                        if (opcode == `OPC_OP && inst[31:25] == `F7_SUB)
                            id_ex_d.alu_op = SUB;
                    end
                endcase
            end
            `OPC_LOAD: begin
                id_ex_d.reg_we  = 1'b1;
                id_ex_d.is_load = (funct3 == `F3_DWORD);
            end
            `OPC_STORE: begin
                id_ex_d.src2     = imm_s;
                id_ex_d.is_store = (funct3 == `F3_DWORD);
            end
            `OPC_JAL: begin
                id_ex_d.src1   = if_id_i.pc;   // link value pc+4
                id_ex_d.src2   = xlen_t'(4);
                id_ex_d.reg_we = 1'b1;
            end
            `OPC_SYSTEM: id_ex_d.is_ebreak = inst[20];
            default: id_ex_d.reg_we = 1'b0;    // branches commit without a write
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i)
            id_ex_o.valid <= 1'b0;
        else if (!stall_i)
            id_ex_o <= id_ex_d;
    end

    // load-use hold lasts one cycle unless memory stalls the pipe
    assert property (@(posedge clk) disable iff (rst_i)
        id_hold_o && !stall_i |=> !id_hold_o);

endmodule

`default_nettype wire

/* verilog/ex_stage.sv */
// single-cycle ALU; SLT is signed and there are no shifts or unsigned compares
`timescale 1ns/1ps
`default_nettype none

module ex_stage import core_pkg::*; (
    input  logic    clk,
    input  logic    rst_i,
    input  logic    stall_i,
    input  id_ex_t  id_ex_i,
    output fwd_t    ex_fwd_o,
    output ex_mem_t ex_mem_o
);

    xlen_t alu_res;

    always_comb begin
        case (id_ex_i.alu_op)
            SUB:     alu_res = id_ex_i.src1 - id_ex_i.src2;
            AND:     alu_res = id_ex_i.src1 & id_ex_i.src2;
            OR:      alu_res = id_ex_i.src1 | id_ex_i.src2;
            XOR:     alu_res = id_ex_i.src1 ^ id_ex_i.src2;
            SLT:     alu_res = xlen_t'($signed(id_ex_i.src1) < $signed(id_ex_i.src2));
            default: alu_res = id_ex_i.src1 + id_ex_i.src2;
        endcase
    end

    // for a load this is only the address; decode holds on is_load
    assign ex_fwd_o = '{valid: id_ex_i.valid && id_ex_i.reg_we, rd: id_ex_i.rd,
                        value: alu_res, is_load: id_ex_i.is_load};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_mem_o.valid <= 1'b0;
        end else if (!stall_i) begin
            ex_mem_o.valid      <= id_ex_i.valid;
            ex_mem_o.pc         <= id_ex_i.pc;
            ex_mem_o.alu_res    <= alu_res;
            ex_mem_o.store_data <= id_ex_i.store_data;
            ex_mem_o.rd         <= id_ex_i.rd;
            ex_mem_o.reg_we     <= id_ex_i.reg_we;
            ex_mem_o.is_load    <= id_ex_i.is_load;
            ex_mem_o.is_store   <= id_ex_i.is_store;
            ex_mem_o.is_ebreak  <= id_ex_i.is_ebreak;
        end
    end

endmodule

`default_nettype wire

/* verilog/mem_stage.sv */
// APB master for 64-bit ld/sd only; pslverr is not checked and pprot/pstrb are not driven
`timescale 1ns/1ps
`default_nettype none

module mem_stage import core_pkg::*; (
    input  logic    clk,
    input  logic    rst_i,
    input  ex_mem_t ex_mem_i,
    output xlen_t   paddr_o,
    output xlen_t   pwdata_o,
    output logic    psel_o,
    output logic    penable_o,
    output logic    pwrite_o,
    input  xlen_t   prdata_i,
    input  logic    pready_i,
    output logic    stall_o,
    output fwd_t    mem_fwd_o,
    output mem_wb_t mem_wb_o
);

    apb_state_e state_q, state;
    logic       mem_req;
    logic       done;

    assign mem_req = ex_mem_i.valid && (ex_mem_i.is_load || ex_mem_i.is_store);

    // SETUP is the first cycle a request sits in this stage
    always_comb begin
        if (state_q == ACCESS)
            state = ACCESS;
        else if (mem_req)
            state = SETUP;
        else
            state = IDLE;
    end

    assign psel_o    = (state != IDLE);
    assign penable_o = (state == ACCESS);
    assign pwrite_o  = ex_mem_i.is_store;
    assign paddr_o   = ex_mem_i.alu_res;     // held by the stall
    assign pwdata_o  = ex_mem_i.store_data;
    assign done      = penable_o && pready_i;
    assign stall_o   = psel_o && !done;

    always_ff @(posedge clk) begin
        if (rst_i)
            state_q <= IDLE;
        else if (state == SETUP)
            state_q <= ACCESS;
        else if (done)
            state_q <= IDLE;
    end

    // prdata only means something on the completing cycle, when decode is released
    assign mem_fwd_o = '{valid: ex_mem_i.valid && ex_mem_i.reg_we, rd: ex_mem_i.rd,
                         value: ex_mem_i.is_load ? prdata_i : ex_mem_i.alu_res,
                         is_load: ex_mem_i.is_load};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mem_wb_o.valid <= 1'b0;
        end else begin
            mem_wb_o.valid     <= ex_mem_i.valid && !stall_o;   // bubble while waiting
            mem_wb_o.pc        <= ex_mem_i.pc;
            mem_wb_o.wdata     <= ex_mem_i.is_load ? prdata_i : ex_mem_i.alu_res;
            mem_wb_o.rd        <= ex_mem_i.rd;
            mem_wb_o.reg_we    <= ex_mem_i.reg_we;
            mem_wb_o.is_ebreak <= ex_mem_i.is_ebreak;
        end
    end

    assert property (@(posedge clk) disable iff (rst_i)
        penable_o |-> psel_o && $past(psel_o));

    assert property (@(posedge clk) disable iff (rst_i)
        psel_o && !done |=> psel_o && $stable(paddr_o));

endmodule

`default_nettype wire

/* verilog/wb_stage.sv */
// register file reads are asynchronous; same-cycle writes reach decode through wb_fwd_o
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module wb_stage import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  mem_wb_t   mem_wb_i,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    output xlen_t     rs1_data_o,
    output xlen_t     rs2_data_o,
    output fwd_t      wb_fwd_o,
    output logic      commit_valid_o,
    output logic      commit_we_o,
    output logic      halt_o,
    output xlen_t     commit_pc_o,
    output xlen_t     commit_wdata_o,
    output reg_addr_t commit_rd_o
);

    xlen_t regs [`REG_NUM];
    logic  rf_we;
    logic  ebreak_commit;
    logic  halt_q;

    assign rf_we         = mem_wb_i.valid && mem_wb_i.reg_we && (mem_wb_i.rd != '0);
    assign ebreak_commit = mem_wb_i.valid && mem_wb_i.is_ebreak;

    always_ff @(posedge clk) begin
        if (rf_we)
            regs[mem_wb_i.rd] <= mem_wb_i.wdata;
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];   // x0 reads zero
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

    assign wb_fwd_o = '{valid: rf_we, rd: mem_wb_i.rd, value: mem_wb_i.wdata, is_load: 1'b0};

    assign commit_valid_o = mem_wb_i.valid;
    assign commit_pc_o    = mem_wb_i.pc;
    assign commit_we_o    = rf_we;
    assign commit_rd_o    = mem_wb_i.rd;
    assign commit_wdata_o = mem_wb_i.wdata;

    always_ff @(posedge clk) begin
        if (rst_i)
            halt_q <= 1'b0;
        else if (ebreak_commit)
            halt_q <= 1'b1;
    end

    assign halt_o = halt_q || ebreak_commit;   // high from the ebreak commit onward

endmodule

`default_nettype wire

/* verilog/core_top.sv */
// the only back-pressure is pready_i; instruction memory must answer combinationally
`timescale 1ns/1ps
`default_nettype none

module core_top import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    output xlen_t     imem_addr_o,
    input  inst_t     imem_data_i,
    output xlen_t     paddr_o,
    output logic      psel_o,
    output logic      penable_o,
    output logic      pwrite_o,
    output xlen_t     pwdata_o,
    input  xlen_t     prdata_i,
    input  logic      pready_i,
    output logic      commit_valid_o,
    output xlen_t     commit_pc_o,
    output logic      commit_we_o,
    output reg_addr_t commit_rd_o,
    output xlen_t     commit_wdata_o,
    output logic      halt_o
);

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;
    fwd_t      ex_fwd, mem_fwd, wb_fwd;
    logic      mem_stall, id_hold, redirect_valid, fetch_stop;
    xlen_t     redirect_pc, rs1_data, rs2_data;
    reg_addr_t rs1_addr, rs2_addr;

    if_stage u_if_stage (
        .clk(clk), .rst_i(rst_i), .stall_i(mem_stall), .id_hold_i(id_hold),
        .redirect_valid_i(redirect_valid), .fetch_stop_i(fetch_stop),
        .redirect_pc_i(redirect_pc), .imem_data_i(imem_data_i),
        .imem_addr_o(imem_addr_o), .if_id_o(if_id)
    );

    id_stage u_id_stage (
        .clk(clk), .rst_i(rst_i), .stall_i(mem_stall), .if_id_i(if_id),
        .ex_fwd_i(ex_fwd), .mem_fwd_i(mem_fwd), .wb_fwd_i(wb_fwd),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .id_hold_o(id_hold), .redirect_valid_o(redirect_valid), .fetch_stop_o(fetch_stop),
        .redirect_pc_o(redirect_pc), .id_ex_o(id_ex)
    );

    ex_stage u_ex_stage (
        .clk(clk), .rst_i(rst_i), .stall_i(mem_stall), .id_ex_i(id_ex),
        .ex_fwd_o(ex_fwd), .ex_mem_o(ex_mem)
    );

    mem_stage u_mem_stage (
        .clk(clk), .rst_i(rst_i), .ex_mem_i(ex_mem),
        .paddr_o(paddr_o), .pwdata_o(pwdata_o), .psel_o(psel_o), .penable_o(penable_o),
        .pwrite_o(pwrite_o), .prdata_i(prdata_i), .pready_i(pready_i),
        .stall_o(mem_stall), .mem_fwd_o(mem_fwd), .mem_wb_o(mem_wb)
    );

    wb_stage u_wb_stage (
        .clk(clk), .rst_i(rst_i), .mem_wb_i(mem_wb),
        .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data), .wb_fwd_o(wb_fwd),
        .commit_valid_o(commit_valid_o), .commit_we_o(commit_we_o), .halt_o(halt_o),
        .commit_pc_o(commit_pc_o), .commit_wdata_o(commit_wdata_o),
        .commit_rd_o(commit_rd_o)
    );

endmodule

`default_nettype wire

/* sim/tb_top.sv */
// each program runs once from reset and must end in ebreak; data memory is 64 dwords on addr[8:3]
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module tb_top import core_pkg::*; ();

    typedef struct packed {
        xlen_t     pc;
        logic      we;
        reg_addr_t rd;
        xlen_t     wdata;
        logic      ebreak;
    } commit_t;

    typedef struct packed {
        logic  write;
        xlen_t addr;
        xlen_t wdata;
    } apb_xfer_t;

    localparam inst_t NOP = 32'h0000_0013;   // addi x0, x0, 0

    logic      clk, rst_i;
    xlen_t     imem_addr_o, imem_off;
    inst_t     imem_data_i;
    xlen_t     paddr_o, pwdata_o, prdata_i;
    logic      psel_o, penable_o, pwrite_o, pready_i;
    logic      commit_valid_o, commit_we_o, halt_o;
    xlen_t     commit_pc_o, commit_wdata_o;
    reg_addr_t commit_rd_o;

    inst_t     rom [64];
    xlen_t     dmem [64];
    xlen_t     model_mem [64];
    xlen_t     model_x [32];
    commit_t   exp_commits [$];
    apb_xfer_t exp_xfers [$];
    int        prog_len, errors, checks, wait_left;
    integer    seed;
    logic      prev_psel, prev_penable, prev_done;
    string     test_name;

    core_top u_dut (
        .clk(clk), .rst_i(rst_i), .imem_addr_o(imem_addr_o), .imem_data_i(imem_data_i),
        .paddr_o(paddr_o), .psel_o(psel_o), .penable_o(penable_o), .pwrite_o(pwrite_o),
        .pwdata_o(pwdata_o), .prdata_i(prdata_i), .pready_i(pready_i),
        .commit_valid_o(commit_valid_o), .commit_pc_o(commit_pc_o), .commit_we_o(commit_we_o),
        .commit_rd_o(commit_rd_o), .commit_wdata_o(commit_wdata_o), .halt_o(halt_o)
    );

    always #2 clk = ~clk;

    always_comb begin
        imem_off    = imem_addr_o - `RESET_PC;
        imem_data_i = (imem_off < 256) ? rom[imem_off[7:2]] : NOP;   // same-cycle ROM
    end

    task automatic check_value(input string what, input xlen_t expected, input xlen_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error %s %s: expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    function automatic inst_t i_word(input logic [6:0] op, input logic [2:0] f3,
                                     input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic inst_t r_word(input logic [6:0] f7, input logic [2:0] f3,
                                     input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `OPC_OP};
    endfunction

    function automatic inst_t s_word(input int rs1, input int rs2, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], `F3_DWORD, imm[4:0], `OPC_STORE};
    endfunction

    function automatic inst_t b_word(input logic [2:0] f3, input int rs1, input int rs2,
                                     input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    function automatic inst_t j_word(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `OPC_JAL};
    endfunction

    function automatic inst_t ebreak_word();
        return {12'h001, 5'd0, 3'd0, 5'd0, `OPC_SYSTEM};
    endfunction

    task automatic clear_rom();
        for (int i = 0; i < 64; i++)
            rom[i] = NOP;
        prog_len = 0;
    endtask

    task automatic emit(input inst_t w);
        rom[prog_len] = w;
        prog_len++;
    endtask

    function automatic inst_t fetch_word(input xlen_t pc);
        xlen_t off;
        off = pc - `RESET_PC;
        return (off < 256) ? rom[off[7:2]] : NOP;
    endfunction

    // reference arithmetic straight from the ISA manual
    function automatic xlen_t alu_model(input logic [2:0] f3, input logic sub,
                                        input xlen_t a, input xlen_t b);
        case (f3)
            `F3_ADD: return sub ? a - b : a + b;
            `F3_SLT: return ($signed(a) < $signed(b)) ? xlen_t'(1) : xlen_t'(0);
            `F3_XOR: return a ^ b;
            `F3_OR:  return a | b;
            `F3_AND: return a & b;
            default: return '0;
        endcase
    endfunction

    // walks the program in order and queues the commits and APB transfers it should produce
    task automatic predict();
        xlen_t     pc, next, a, b, res, addr;
        xlen_t     imm_i, imm_s, imm_b, imm_j;
        inst_t     w;
        commit_t   c;
        apb_xfer_t x;
        logic      writes, done;
        int        steps;
        pc = `RESET_PC;
        done = 1'b0;
        steps = 0;
        exp_commits.delete();
        exp_xfers.delete();
        while (!done && steps < 64) begin
            w     = fetch_word(pc);
            a     = model_x[w[19:15]];
            b     = model_x[w[24:20]];
            imm_i = {{52{w[31]}}, w[31:20]};
            imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
            imm_b = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            imm_j = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            c = '0;
            c.pc = pc;
            c.rd = w[11:7];
            next = pc + 4;
            writes = 1'b0;
            res = '0;
            case (w[6:0])
                `OPC_OP_IMM: begin
                    res = alu_model(w[14:12], 1'b0, a, imm_i);
                    writes = 1'b1;
                end
                `OPC_OP: begin
                    res = alu_model(w[14:12], w[30], a, b);
                    writes = 1'b1;
                end
                `OPC_LOAD: begin
                    addr = a + imm_i;
                    res = model_mem[addr[8:3]];
                    writes = 1'b1;
                    x.write = 1'b0;
                    x.addr = addr;
                    x.wdata = '0;
                    exp_xfers.push_back(x);
                end
                `OPC_STORE: begin
                    addr = a + imm_s;
                    model_mem[addr[8:3]] = b;
                    x.write = 1'b1;
                    x.addr = addr;
                    x.wdata = b;
                    exp_xfers.push_back(x);
                end
                `OPC_BRANCH: begin
                    if ((w[14:12] == `F3_BEQ && a == b) || (w[14:12] == `F3_BNE && a != b))
                        next = pc + imm_b;
                end
                `OPC_JAL: begin
                    res = pc + 4;
                    writes = 1'b1;
                    next = pc + imm_j;
                end
                default: begin   // ebreak ends the program
                    c.ebreak = 1'b1;
                    done = 1'b1;
                end
            endcase
            c.we = writes && (c.rd != 0);
            c.wdata = res;
            if (c.we)
                model_x[c.rd] = res;
            exp_commits.push_back(c);
            pc = next;
            steps++;
        end
    endtask

    always @(posedge clk) begin : commit_monitor
        commit_t c;
        if (!rst_i && commit_valid_o) begin
            if (exp_commits.size() == 0) begin
                errors++;
                $display("%s: unexpected commit at pc %h", test_name, commit_pc_o);
            end else begin
                c = exp_commits.pop_front();
                check_value("commit_pc", c.pc, commit_pc_o);
                check_value("commit_we", c.we, commit_we_o);
                check_value("halt_o", c.ebreak, halt_o);
                if (c.we) begin
                    check_value("commit_rd", c.rd, commit_rd_o);
                    check_value("commit_wdata", c.wdata, commit_wdata_o);
                end
            end
        end
    end

    // APB slave with 0 to 3 wait states per transfer
    always @(posedge clk) begin : apb_slave
        apb_xfer_t x;
        if (rst_i) begin
            prev_psel = 1'b0;
            prev_penable = 1'b0;
            prev_done = 1'b0;
        end else begin
            if (penable_o && (!prev_psel || prev_done)) begin
                errors++;
                $display("%s: APB access phase started without a setup cycle", test_name);
            end
            if (prev_psel && !prev_penable && !(psel_o && penable_o)) begin
                errors++;
                $display("%s: APB setup cycle was not followed by an access", test_name);
            end
            if (psel_o && penable_o && pready_i) begin
                if (exp_xfers.size() == 0) begin
                    errors++;
                    $display("%s: unexpected APB transfer to %h", test_name, paddr_o);
                end else begin
                    x = exp_xfers.pop_front();
                    check_value("paddr", x.addr, paddr_o);
                    check_value("pwrite", x.write, pwrite_o);
                    if (x.write)
                        check_value("pwdata", x.wdata, pwdata_o);
                end
                if (pwrite_o)
                    dmem[paddr_o[8:3]] = pwdata_o;
            end
            prev_done = psel_o && penable_o && pready_i;   // next transfer needs a new setup
            prev_psel = psel_o;
            prev_penable = penable_o;
        end
        #1;
        if (psel_o && !penable_o) begin
            wait_left = $unsigned($random(seed)) % 4;
            pready_i = 1'b0;
        end else if (psel_o && penable_o) begin
            pready_i = (wait_left == 0);
            if (wait_left != 0)
                wait_left--;
        end else begin
            pready_i = 1'b0;
        end
        prdata_i = psel_o ? dmem[paddr_o[8:3]] : '0;
    end

    task automatic run_program(input string name);
        int cycles;
        test_name = name;
        @(posedge clk);
        #1 rst_i = 1'b1;
        predict();
        repeat (4) @(posedge clk);
        #1 rst_i = 1'b0;
        check_value("commit_valid after reset", 0, commit_valid_o);
        check_value("psel after reset", 0, psel_o);
        check_value("penable after reset", 0, penable_o);
        check_value("halt after reset", 0, halt_o);
        check_value("first fetch address", `RESET_PC, imem_addr_o);
        cycles = 0;
        while (exp_commits.size() != 0 && cycles < 300) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_commits.size() != 0) begin
            errors++;
            $display("%s: timed out with %0d commits still missing", name, exp_commits.size());
        end
        repeat (20) @(posedge clk);   // nothing may commit after the halt
        if (exp_xfers.size() != 0) begin
            errors++;
            $display("%s: %0d APB transfers never happened", name, exp_xfers.size());
        end
        check_value("halt_o held", 1, halt_o);
    endtask

    task automatic reset_values();
        clear_rom();
        emit(i_word(`OPC_OP_IMM, `F3_ADD, 1, 0, 1));
        emit(ebreak_word());
        run_program("reset");
    endtask

    task automatic alu_chain();
        clear_rom();
        emit(i_word(`OPC_OP_IMM, `F3_ADD, 1, 0, 25));
        emit(i_word(`OPC_OP_IMM, `F3_ADD, 2, 1, -7));
        emit(r_word(7'd0, `F3_ADD, 3, 1, 2));
        emit(r_word(`F7_SUB, `F3_ADD, 4, 3, 1));
        emit(r_word(7'd0, `F3_AND, 5, 4, 3));
        emit(r_word(7'd0, `F3_OR, 6, 5, 1));
        emit(r_word(7'd0, `F3_XOR, 7, 6, 4));
        emit(r_word(7'd0, `F3_SLT, 8, 4, 3));
        emit(r_word(7'd0, `F3_SLT, 9, 3, 4));
        emit(i_word(`OPC_OP_IMM, `F3_ADD, 0, 7, 5));   // x0 stays zero
        emit(r_word(7'd0, `F3_ADD, 10, 0, 7));
        emit(r_word(`F7_SUB, `F3_ADD, 11, 2, 3));
        emit(r_word(7'd0, `F3_SLT, 12, 11, 0));         // negative vs zero
        emit(ebreak_word());
        run_program("forwarding");
    endtask

    task automatic load_store();
        clear_rom();
        emit(i_word(`OPC_OP_IMM, `F3_ADD, 1, 0, 'h100));
        emit(i_word(`OPC_OP_IMM, `F3_ADD, 2, 0, -1234));
        emit(s_word(1, 2, 8));
        emit(i_word(`OPC_LOAD, `F3_DWORD, 3, 1, 8));
        emit(r_word(7'd0, `F3_ADD, 4, 3, 1));           // load-use
        emit(s_word(1, 4, 16));
        emit(i_word(`OPC_LOAD, `F3_DWORD, 5, 1, 16));
        emit(r_word(`F7_SUB, `F3_ADD, 6, 5, 3));
        emit(i_word(`OPC_LOAD, `F3_DWORD, 7, 1, 24));   // untouched fill word
        emit(ebreak_word());
        run_program("memory");
    endtask

    task automatic branch_jump();
        clear_rom();
        emit(i_word(`OPC_OP_IMM, `F3_ADD, 1, 0, 5));
        emit(i_word(`OPC_OP_IMM, `F3_ADD, 2, 0, 5));
        emit(b_word(`F3_BEQ, 1, 2, 8));
        emit(i_word(`OPC_OP_IMM, `F3_ADD, 3, 0, 99));   // wrong path
        emit(b_word(`F3_BNE, 1, 2, 8));
        emit(i_word(`OPC_OP_IMM, `F3_ADD, 4, 0, 7));
        emit(j_word(5, 12));
        emit(i_word(`OPC_OP_IMM, `F3_ADD, 6, 0, 1));    // wrong path
        emit(i_word(`OPC_OP_IMM, `F3_ADD, 7, 0, 2));    // wrong path
        emit(b_word(`F3_BEQ, 4, 1, 8));
        emit(b_word(`F3_BNE, 4, 1, 8));
        emit(i_word(`OPC_OP_IMM, `F3_ADD, 8, 0, 3));    // wrong path
        emit(i_word(`OPC_OP_IMM, `F3_ADD, 9, 5, 0));
        emit(i_word(`OPC_OP_IMM, `F3_ADD, 10, 0, 3));
        emit(i_word(`OPC_OP_IMM, `F3_ADD, 10, 10, -1));
        emit(b_word(`F3_BNE, 10, 0, -4));               // backward loop, three passes
        emit(ebreak_word());
        run_program("branches");
    endtask

    task automatic ebreak_halt();
        clear_rom();
        emit(i_word(`OPC_OP_IMM, `F3_ADD, 1, 0, 1));
        emit(ebreak_word());
        emit(i_word(`OPC_OP_IMM, `F3_ADD, 2, 0, 2));    // must never commit
        run_program("halt");
    endtask

    initial begin
        clk = 1'b0;
        rst_i = 1'b1;
        pready_i = 1'b0;
        prdata_i = '0;
        seed = 32'ha449;
        errors = 0;
        checks = 0;
        wait_left = 0;
        prev_psel = 1'b0;
        prev_penable = 1'b0;
        prev_done = 1'b0;
        test_name = "init";
        for (int i = 0; i < 32; i++)
            model_x[i] = '0;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = {16'hd0d0, 16'(i * 8), ~32'(i * 8)};
            model_mem[i] = dmem[i];
        end
        reset_values();
        alu_chain();
        load_store();
        branch_jump();
        ebreak_halt();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+verilog
verilog/core_pkg.sv
verilog/if_stage.sv
verilog/id_stage.sv
verilog/ex_stage.sv
verilog/mem_stage.sv
verilog/wb_stage.sv
verilog/core_top.sv
sim/tb_top.sv
